// ==== include/arcade_input_cfg.svh ====
// Build-time sizes for the arcade input front end, included by the package and the RTL
`ifndef ARCADE_INPUT_CFG_SVH
`define ARCADE_INPUT_CFG_SVH

//////////////////////////////////////////////////
// Player ports
//////////////////////////////////////////////////

// Number of player ports
// The package key table has two rows, so only 2 works
`define ARCADE_NUM_PLAYERS 2

//////////////////////////////////////////////////
// Reset timing
//////////////////////////////////////////////////

// Cycles of PLL reset after the PLL drops lock
`define ARCADE_PLL_STRETCH 256

// Cycles of CPU reset after its last cause goes away
`define ARCADE_CPU_RST_CYCLES 16

//////////////////////////////////////////////////
// Host bus
//////////////////////////////////////////////////

// Wishbone word address width
`define ARCADE_WB_ADR_W 3

`endif

// ==== hdl/arcade_input_pkg.sv ====
// Shared types and key code tables for the arcade input front end; referenced by scoped names
`include "arcade_input_cfg.svh"

package arcade_input_pkg;

  //////////////////////////////////////////////////
  // Player control word
  //////////////////////////////////////////////////

  // Declared MSB first, so right lands on bit 0
  // Same bit order as the low 11 joystick bits
  typedef struct packed {
    logic service;
    logic pause;
    logic coin;
    logic start;
    logic button3;
    logic button2;
    logic button1;
    logic up;
    logic down;
    logic left;
    logic right;
  } player_ctrl_t;

  // Bit index of each control field
  typedef enum logic [3:0] {
    CTRL_RIGHT,
    CTRL_LEFT,
    CTRL_DOWN,
    CTRL_UP,
    CTRL_BUTTON1,
    CTRL_BUTTON2,
    CTRL_BUTTON3,
    CTRL_START,
    CTRL_COIN,
    CTRL_PAUSE,
    CTRL_SERVICE
  } ctrl_bit_e;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  typedef enum logic [`ARCADE_WB_ADR_W-1:0] {
    REG_PLAYER0 = 3'd0,
    REG_PLAYER1 = 3'd1,
    REG_COINS   = 3'd2,
    REG_OPTIONS = 3'd3,
    REG_CONTROL = 3'd4
  } reg_addr_e;

  //////////////////////////////////////////////////
  // PS/2 scan codes per player, indexed by ctrl_bit_e
  //////////////////////////////////////////////////

  // Code 00 marks an unmapped field
  localparam logic [7:0] key_table [`ARCADE_NUM_PLAYERS][11] = '{
    // Arrows, ctrl, alt, space, 1, 5, P, 9
    '{8'h74, 8'h6B, 8'h72, 8'h75, 8'h14, 8'h11, 8'h29, 8'h16, 8'h2E, 8'h4D, 8'h46},
    // G, D, F, R, A, S, Q, 2, 6, no pause key, 0
    '{8'h34, 8'h23, 8'h2B, 8'h2D, 8'h1C, 8'h1B, 8'h15, 8'h1E, 8'h36, 8'h00, 8'h45}
  };

endpackage

// ==== hdl/key_event_if.sv ====
// Decoded PS/2 key event bundle, driven by the key decoder and read by every player port
`timescale 1ns/1ps

interface key_event_if;

  // One-cycle strobe, no back-pressure
  logic       valid;
  // Scan code, low byte only
  logic [7:0] code;
  // Make (1) or break (0)
  logic       pressed;
  // E0-prefixed key
  logic       extended;

  // Decoder side
  modport src (
    output valid,
    output code,
    output pressed,
    output extended
  );

  // Player port side
  modport dst (
    input valid,
    input code,
    input pressed,
    input extended
  );

endinterface

// ==== hdl/ps2_key_decoder.sv ====
// PS/2 key word decoder; a flip of the toggle bit becomes a one-cycle key event
`timescale 1ns/1ps

module ps2_key_decoder (
  input  logic        clk_sys,
  input  logic        RESET,
  input  logic [10:0] ps2_key,
  key_event_if.src    ev
);

  // Input capture of the key word
  logic       tog_in;
  logic [9:0] key_in;
  // Toggle as seen one cycle before
  logic       tog_prev;

  //////////////////////////////////////////////////
  // Toggle tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      tog_in   <= 1'b0;
      tog_prev <= 1'b0;
      ev.valid <= 1'b0;
    end else begin
      tog_in   <= ps2_key[10];
      tog_prev <= tog_in;
      // Any change of the toggle marks a new event
      ev.valid <= tog_in ^ tog_prev;
    end
  end

  //////////////////////////////////////////////////
  // Event payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys) begin
    key_in      <= ps2_key[9:0];
    // Payload lines up with the valid pulse
    ev.code     <= key_in[7:0];
    ev.extended <= key_in[8];
    ev.pressed  <= key_in[9];
  end

endmodule

// ==== hdl/player_port.sv ====
// One player's input port; tracks mapped key states and merges them with the joystick word
`timescale 1ns/1ps

module player_port #(
  // Row of the key table, 0 or 1
  parameter int PLAYER = 0
) (
  input  logic                         clk_sys,
  input  logic                         RESET,
  key_event_if.dst                     ev,
  input  logic [10:0]                  joystick,
  output arcade_input_pkg::player_ctrl_t ctrl
);

  // Held state of each mapped key, bit order as in player_ctrl_t
  logic [10:0] keys_q;
  // Key state with the current event applied
  logic [10:0] keys_next;

  //////////////////////////////////////////////////
  // Key match
  //////////////////////////////////////////////////

  // Extended and plain codes match the same entry
  always_comb begin
    keys_next = keys_q;
    if (ev.valid) begin
      for (int i = 0; i <= int'(arcade_input_pkg::CTRL_SERVICE); i++) begin
        // Entry 00 is unmapped and never hits
        if (arcade_input_pkg::key_table[PLAYER][i] != 8'h00 &&
            ev.code == arcade_input_pkg::key_table[PLAYER][i]) begin
          keys_next[i] = ev.pressed;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // State and output
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      keys_q <= '0;
      ctrl   <= '0;
    end else begin
      keys_q <= keys_next;
      // Event shows in the cycle after valid, joystick one cycle late
      ctrl   <= arcade_input_pkg::player_ctrl_t'(keys_next | joystick);
    end
  end

endmodule

// ==== hdl/input_regs.sv ====
// Wishbone classic register block for player readback, coin counts, options and soft reset
`timescale 1ns/1ps
`include "arcade_input_cfg.svh"

module input_regs (
  input  logic                           clk_sys,
  input  logic                           RESET,
  input  arcade_input_pkg::player_ctrl_t players [`ARCADE_NUM_PLAYERS],
  input  logic                           wb_cyc,
  input  logic                           wb_stb,
  input  logic                           wb_we,
  input  logic [`ARCADE_WB_ADR_W-1:0]    wb_adr,
  input  logic [31:0]                    wb_dat_w,
  output logic [31:0]                    wb_dat_r,
  output logic                           wb_ack,
  output logic [31:0]                    options,
  output logic                           soft_reset
);

  // New request, only seen while ack is low
  logic        req;
  logic        wr;
  logic [31:0] rd_data;
  // Coin bit of the previous cycle, per player
  logic [`ARCADE_NUM_PLAYERS-1:0] coin_q;
  // Wrapping coin counters
  logic [7:0]  coin_cnt [`ARCADE_NUM_PLAYERS];

  assign req = wb_cyc & wb_stb & ~wb_ack;
  assign wr  = req & wb_we;

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    case (arcade_input_pkg::reg_addr_e'(wb_adr))
      arcade_input_pkg::REG_PLAYER0: rd_data = {21'h0, players[0]};
      arcade_input_pkg::REG_PLAYER1: rd_data = {21'h0, players[1]};
      arcade_input_pkg::REG_COINS:   rd_data = {16'h0, coin_cnt[1], coin_cnt[0]};
      arcade_input_pkg::REG_OPTIONS: rd_data = options;
      // Control reads 0, as do holes in the map
      default:                       rd_data = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Bus handshake and writes
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      wb_ack     <= 1'b0;
      options    <= '0;
      soft_reset <= 1'b0;
    end else begin
      // Single-cycle ack, one cycle after the request
      wb_ack     <= req;
      soft_reset <= 1'b0;
      if (wr) begin
        case (arcade_input_pkg::reg_addr_e'(wb_adr))
          arcade_input_pkg::REG_OPTIONS: options <= wb_dat_w;
          arcade_input_pkg::REG_CONTROL: soft_reset <= wb_dat_w[0];
          // Coin clear lives with the counters, rest ignored
          default: ;
        endcase
      end
    end
  end

  // Read data rides along with ack
  always_ff @(posedge clk_sys) begin
    if (req) begin
      wb_dat_r <= rd_data;
    end
  end

  //////////////////////////////////////////////////
  // Coin counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      coin_q <= '0;
      for (int p = 0; p < `ARCADE_NUM_PLAYERS; p++) begin
        coin_cnt[p] <= 8'h00;
      end
    end else begin
      for (int p = 0; p < `ARCADE_NUM_PLAYERS; p++) begin
        coin_q[p] <= players[p].coin;
        // Host clear beats a coin edge in the same cycle
        if (wr && wb_adr == arcade_input_pkg::REG_COINS) begin
          coin_cnt[p] <= 8'h00;
        end else if (players[p].coin && !coin_q[p]) begin
          coin_cnt[p] <= coin_cnt[p] + 8'h01;
        end
      end
    end
  end

endmodule

// ==== hdl/reset_gen.sv ====
// Reset generator; stretches the PLL reset on lock loss and holds the CPU reset after its causes
`timescale 1ns/1ps
`include "arcade_input_cfg.svh"

module reset_gen (
  input  logic clk_sys,
  input  logic RESET,
  input  logic pll_locked,
  input  logic soft_reset,
  output logic pll_rst,
  output logic cpu_reset
);

  localparam int PLL_W = $clog2(`ARCADE_PLL_STRETCH);
  localparam int CPU_W = $clog2(`ARCADE_CPU_RST_CYCLES + 1);

  logic             locked_q;
  logic [PLL_W-1:0] pll_cnt;
  logic [CPU_W-1:0] cpu_cnt;
  // CPU reset causes other than RESET itself
  logic             cpu_cause;

  assign cpu_cause = ~pll_locked | soft_reset;

  //////////////////////////////////////////////////
  // PLL reset stretch
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      locked_q <= 1'b0;
      pll_cnt  <= '0;
      pll_rst  <= 1'b0;
    end else begin
      locked_q <= pll_locked;
      if (locked_q && !pll_locked) begin
        // Falling lock, load the full stretch
        pll_cnt <= PLL_W'(`ARCADE_PLL_STRETCH - 1);
        pll_rst <= 1'b1;
      end else if (pll_cnt != '0) begin
        pll_cnt <= pll_cnt - 1'b1;
      end else begin
        pll_rst <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // CPU reset hold
  //////////////////////////////////////////////////

  // Release of RESET already counts as the first hold cycle
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      cpu_cnt   <= CPU_W'(`ARCADE_CPU_RST_CYCLES - 1);
      cpu_reset <= 1'b1;
    end else begin
      if (cpu_cause) begin
        // Reload while any cause is present
        cpu_cnt   <= CPU_W'(`ARCADE_CPU_RST_CYCLES);
        cpu_reset <= 1'b1;
      end else if (cpu_cnt != '0) begin
        cpu_cnt   <= cpu_cnt - 1'b1;
      end else begin
        cpu_reset <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/arcade_input_top.sv ====
// Top level of the arcade input front end; ties key decoder, player ports, registers and resets
`timescale 1ns/1ps
`include "arcade_input_cfg.svh"

module arcade_input_top (
  input  logic                        clk_sys,
  input  logic                        RESET,
  input  logic [10:0]                 ps2_key,
  input  logic [31:0]                 joystick_0,
  input  logic [31:0]                 joystick_1,
  input  logic                        pll_locked,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [`ARCADE_WB_ADR_W-1:0] wb_adr,
  input  logic [31:0]                 wb_dat_w,
  output logic [31:0]                 wb_dat_r,
  output logic                        wb_ack,
  output logic [10:0]                 p0_ctrl,
  output logic [10:0]                 p1_ctrl,
  output logic [31:0]                 options,
  output logic                        pll_rst,
  output logic                        cpu_reset
);

  // Shared key event bus
  key_event_if key_ev ();

  // Per-player control words and joystick slices
  arcade_input_pkg::player_ctrl_t players [`ARCADE_NUM_PLAYERS];
  logic [10:0]                    joy_low [`ARCADE_NUM_PLAYERS];
  logic                           soft_reset;

  // Only the low 11 joystick bits carry controls
  assign joy_low[0] = joystick_0[10:0];
  assign joy_low[1] = joystick_1[10:0];

  assign p0_ctrl = players[0];
  assign p1_ctrl = players[1];

  //////////////////////////////////////////////////
  // Keyboard and player ports
  //////////////////////////////////////////////////

  ps2_key_decoder ps2_key_decoder_i (
    .clk_sys (clk_sys),
    .RESET   (RESET),
    .ps2_key (ps2_key),
    .ev      (key_ev.src)
  );

  for (genvar p = 0; p < `ARCADE_NUM_PLAYERS; p++) begin : g_player
    player_port #(
      .PLAYER (p)
    ) player_port_i (
      .clk_sys  (clk_sys),
      .RESET    (RESET),
      .ev       (key_ev.dst),
      .joystick (joy_low[p]),
      .ctrl     (players[p])
    );
  end

  //////////////////////////////////////////////////
  // Host registers and resets
  //////////////////////////////////////////////////

  input_regs input_regs_i (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .players    (players),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .options    (options),
    .soft_reset (soft_reset)
  );

  reset_gen reset_gen_i (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .pll_locked (pll_locked),
    .soft_reset (soft_reset),
    .pll_rst    (pll_rst),
    .cpu_reset  (cpu_reset)
  );

endmodule

// ==== verification/arcade_input_assert.sv ====
// Concurrent checks on the Wishbone handshake and the key event strobe, attached to the RTL by bind
`timescale 1ns/1ps

module arcade_input_assert (
  input logic clk_sys,
  input logic RESET,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic valid
);

  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk_sys) disable iff (RESET) wb_ack |=> !wb_ack)
    else $error("wb_ack stayed high for more than one cycle");

  // Ack only answers a request seen on the edge before
  ack_after_req: assert property (@(posedge clk_sys) disable iff (RESET)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack rose without a preceding request");

  // Event strobe never stretches
  valid_one_cycle: assert property (@(posedge clk_sys) disable iff (RESET) valid |=> !valid)
    else $error("key event valid stayed high for more than one cycle");

endmodule

//////////////////////////////////////////////////
// Attachments
//////////////////////////////////////////////////

// Bus checks on the register block
bind input_regs arcade_input_assert input_regs_assert_i (
  .clk_sys (clk_sys),
  .RESET   (RESET),
  .wb_cyc  (wb_cyc),
  .wb_stb  (wb_stb),
  .wb_ack  (wb_ack),
  .valid   (1'b0)
);

// Event checks on the decoder
bind ps2_key_decoder arcade_input_assert ps2_key_decoder_assert_i (
  .clk_sys (clk_sys),
  .RESET   (RESET),
  .wb_cyc  (1'b0),
  .wb_stb  (1'b0),
  .wb_ack  (1'b0),
  .valid   (ev.valid)
);

// ==== verification/arcade_input_tb.sv ====
// Random-stimulus testbench for the arcade input front end; drives the top level against a model
`timescale 1ns/1ps
`include "arcade_input_cfg.svh"

module arcade_input_tb;

  localparam int N_KEYS   = 300;
  localparam int N_JOY    = 100;
  localparam int N_COIN   = 80;
  localparam int N_OPT    = 40;
  localparam int COIN_BIT = 8;
  // Rough cycles per step of each test, plus the reset tests and margin
  localparam int TIMEOUT_CYCLES = 8 + 40 + N_KEYS * 6 + N_JOY * 12 + N_COIN * 8
                                  + N_OPT * 24 + `ARCADE_PLL_STRETCH + 128 + 500;

  // Scan codes per player and control bit
  // Code 00 is unmapped
  localparam logic [7:0] CODES [2][11] = '{
    '{8'h74, 8'h6B, 8'h72, 8'h75, 8'h14, 8'h11, 8'h29, 8'h16, 8'h2E, 8'h4D, 8'h46},
    '{8'h34, 8'h23, 8'h2B, 8'h2D, 8'h1C, 8'h1B, 8'h15, 8'h1E, 8'h36, 8'h00, 8'h45}
  };

  logic                        clk_sys;
  logic                        RESET;
  logic [10:0]                 ps2_key;
  logic [31:0]                 joystick_0;
  logic [31:0]                 joystick_1;
  logic                        pll_locked;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        wb_we;
  logic [`ARCADE_WB_ADR_W-1:0] wb_adr;
  logic [31:0]                 wb_dat_w;
  logic [31:0]                 wb_dat_r;
  logic                        wb_ack;
  logic [10:0]                 p0_ctrl;
  logic [10:0]                 p1_ctrl;
  logic [31:0]                 options;
  logic                        pll_rst;
  logic                        cpu_reset;

  //////////////////////////////////////////////////
  // Model state
  //////////////////////////////////////////////////

  logic [10:0] keys_m [2];
  logic [10:0] joy_m [2];
  logic [10:0] ctrl_m [2];
  // Coin edge counts that wrap at 256
  logic [7:0]  coins_m [2];
  logic [31:0] options_m;
  int          value_errors = 0;
  int          bus_errors = 0;
  int          cycles = 0;

  arcade_input_top arcade_input_top_i (.*);

  initial begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;
  end

  // Run limit
  always @(posedge clk_sys) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic compare_ctrl(input string name, input arcade_input_pkg::player_ctrl_t exp,
                              input arcade_input_pkg::player_ctrl_t act);
    if (act !== exp) begin
      value_errors++;
      $display("** Error %s: expected %03h, actual %03h", name, exp, act);
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("** Error %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic expect_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Model and stimulus helpers
  //////////////////////////////////////////////////

  // Rebuild the ctrl words and count rising coin bits
  task automatic refresh_model();
    logic [10:0] next;
    for (int p = 0; p < 2; p++) begin
      next = keys_m[p] | joy_m[p];
      if (next[COIN_BIT] && !ctrl_m[p][COIN_BIT]) begin
        coins_m[p] = coins_m[p] + 8'd1;
      end
      ctrl_m[p] = next;
    end
  endtask

  task automatic both_ctrl(input string name);
    compare_ctrl({name, " p0"}, ctrl_m[0], p0_ctrl);
    compare_ctrl({name, " p1"}, ctrl_m[1], p1_ctrl);
  endtask

  // Toggle flip marks a new key event that shows on ctrl 3 cycles later
  task automatic send_key(input logic [7:0] code, input logic pressed, input logic ext);
    @(posedge clk_sys);
    ps2_key <= {~ps2_key[10], pressed, ext, code};
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < 11; i++) begin
        if (CODES[p][i] != 8'h00 && CODES[p][i] == code) begin
          keys_m[p][i] = pressed;
        end
      end
    end
    refresh_model();
    repeat (3) @(posedge clk_sys);
    @(negedge clk_sys);
    both_ctrl("key event");
  endtask

  // Payload that would flip player 0's right key while the toggle stays put
  task automatic hold_toggle();
    @(posedge clk_sys);
    ps2_key <= {ps2_key[10], ~keys_m[0][0], 1'($urandom), CODES[0][0]};
    repeat (3) @(posedge clk_sys);
    @(negedge clk_sys);
    both_ctrl("steady toggle");
  endtask

  task automatic set_joysticks(input logic [31:0] j0, input logic [31:0] j1);
    @(posedge clk_sys);
    joystick_0 <= j0;
    joystick_1 <= j1;
    joy_m[0] = j0[10:0];
    joy_m[1] = j1[10:0];
    refresh_model();
    @(posedge clk_sys);
    @(negedge clk_sys);
    both_ctrl("joystick");
  endtask

  // One Wishbone classic cycle with ack sampled on falling edges
  task automatic bus_cycle(input logic we, input logic [`ARCADE_WB_ADR_W-1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    @(posedge clk_sys);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    waited = 0;
    rdata  = '0;
    do begin
      @(negedge clk_sys);
      waited++;
    end while (!wb_ack && waited < 8);
    if (wb_ack) begin
      rdata = wb_dat_r;
    end else begin
      bus_errors++;
      $display("Bus failure: no wb_ack for access to address %0d", adr);
    end
    @(posedge clk_sys);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_reg(input logic [`ARCADE_WB_ADR_W-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic read_reg(input logic [`ARCADE_WB_ADR_W-1:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'h0, data);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [7:0]  code;
    int          p;
    int          idx;
    int          n;
    void'($urandom(82719));
    RESET = 1'b1;
    ps2_key = '0;
    joystick_0 = '0;
    joystick_1 = '0;
    pll_locked = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    options_m = '0;
    for (int i = 0; i < 2; i++) begin
      keys_m[i] = '0;
      joy_m[i] = '0;
      ctrl_m[i] = '0;
      coins_m[i] = '0;
    end

    // Reset levels and the 16-cycle CPU reset hold
    repeat (8) @(posedge clk_sys);
    RESET <= 1'b0;
    @(negedge clk_sys);
    expect_level("reset wb_ack", 1'b0, wb_ack);
    expect_level("reset pll_rst", 1'b0, pll_rst);
    expect_level("reset cpu_reset", 1'b1, cpu_reset);
    both_ctrl("reset");
    compare_word("reset options", 32'h0, options);
    n = 0;
    while (cpu_reset && n < 64) begin
      n++;
      @(negedge clk_sys);
    end
    compare_word("cpu_reset after RESET", 32'd16, n);
    read_reg(arcade_input_pkg::REG_COINS, rd);
    compare_word("reset coins", 32'h0, rd);

    // Key events with codes for either player or random codes
    for (int i = 0; i < N_KEYS; i++) begin
      p = $urandom_range(0, 2);
      idx = $urandom_range(0, 10);
      code = (p < 2) ? CODES[p][idx] : 8'($urandom);
      send_key(code, 1'($urandom), 1'($urandom));
      if (i % 10 == 0) begin
        hold_toggle();
      end
    end

    // Joysticks over held keys with register readback
    for (int i = 0; i < N_JOY; i++) begin
      set_joysticks($urandom, $urandom);
      read_reg(arcade_input_pkg::REG_PLAYER0, rd);
      compare_word("REG_PLAYER0", {21'h0, ctrl_m[0]}, rd);
      read_reg(arcade_input_pkg::REG_PLAYER1, rd);
      compare_word("REG_PLAYER1", {21'h0, ctrl_m[1]}, rd);
    end

    // Coin presses from keys and joysticks
    for (int i = 0; i < N_COIN; i++) begin
      p = $urandom_range(0, 1);
      if ($urandom_range(0, 1) == 0) begin
        send_key(CODES[p][COIN_BIT], 1'($urandom), 1'b0);
      end else begin
        set_joysticks(joystick_0 ^ ((p == 0) ? 32'h100 : 32'h0),
                      joystick_1 ^ ((p == 1) ? 32'h100 : 32'h0));
      end
      if (i % 8 == 7) begin
        read_reg(arcade_input_pkg::REG_COINS, rd);
        compare_word("REG_COINS", {16'h0, coins_m[1], coins_m[0]}, rd);
      end
    end
    write_reg(arcade_input_pkg::REG_COINS, $urandom);
    coins_m[0] = '0;
    coins_m[1] = '0;
    read_reg(arcade_input_pkg::REG_COINS, rd);
    compare_word("REG_COINS after clear", 32'h0, rd);

    // Option word and holes in the map
    for (int i = 0; i < N_OPT; i++) begin
      options_m = $urandom;
      write_reg(arcade_input_pkg::REG_OPTIONS, options_m);
      read_reg(arcade_input_pkg::REG_OPTIONS, rd);
      compare_word("REG_OPTIONS", options_m, rd);
      compare_word("options port", options_m, options);
      idx = $urandom_range(5, 7);
      write_reg(3'(idx), $urandom);
      read_reg(3'(idx), rd);
      compare_word("undefined address", 32'h0, rd);
      read_reg(arcade_input_pkg::REG_CONTROL, rd);
      compare_word("REG_CONTROL", 32'h0, rd);
      compare_word("options after hole write", options_m, options);
    end

    // Lock loss gives 256 cycles of PLL reset
    @(posedge clk_sys);
    pll_locked <= 1'b0;
    @(negedge clk_sys);
    idx = 0;
    while (!pll_rst && idx < 4) begin
      idx++;
      @(negedge clk_sys);
    end
    n = 0;
    while (pll_rst && n < 400) begin
      n++;
      @(negedge clk_sys);
    end
    compare_word("pll_rst stretch", 32'd256, n);
    @(posedge clk_sys);
    pll_locked <= 1'b1;
    idx = 0;
    while (cpu_reset && idx < 64) begin
      idx++;
      @(negedge clk_sys);
    end
    expect_level("cpu_reset after relock", 1'b0, cpu_reset);

    // Soft reset length counted from the cycle after ack
    write_reg(arcade_input_pkg::REG_CONTROL, 32'h1);
    @(negedge clk_sys);
    n = 0;
    while (cpu_reset && n < 64) begin
      n++;
      @(negedge clk_sys);
    end
    compare_word("soft reset length", 32'd17, n);

    $display("Run complete: %0d value errors, %0d bus errors", value_errors, bus_errors);
    if (value_errors == 0 && bus_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== arcade_input.f ====
+incdir+include
hdl/arcade_input_pkg.sv
hdl/key_event_if.sv
hdl/ps2_key_decoder.sv
hdl/player_port.sv
hdl/input_regs.sv
hdl/reset_gen.sv
hdl/arcade_input_top.sv
verification/arcade_input_assert.sv
verification/arcade_input_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the arcade input testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f arcade_input.f \
  --top-module arcade_input_tb \
  -o arcade_input_sim

./obj_dir/arcade_input_sim | tee "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failure"
